/* exe_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module exe_alu (
    input  wire logic                                clk_i,
    input  wire logic                                arst_n_i,
    input  wire mips_exe_pkg::exe_req_t              req_i,
    input  wire logic [mips_exe_pkg::DataW-1:0]      hi_i,
    input  wire logic [mips_exe_pkg::DataW-1:0]      lo_i,
    input  wire logic [mips_exe_pkg::DataW-1:0]      cp0_rdata_i,
    input  wire mips_exe_pkg::cp0_wr_t               mem_cp0_i,
    input  wire mips_exe_pkg::cp0_wr_t               wb_cp0_i,
    input  wire logic [mips_exe_pkg::DataW-1:0]      div_q_i,
    input  wire logic [mips_exe_pkg::DataW-1:0]      div_r_i,
    input  wire logic                                div_ready_i,
    output logic                                     div_start_o,
    output logic                                     div_signed_o,
    output mips_exe_pkg::exe_res_t                   res_o,
    output mips_exe_pkg::cp0_wr_t                    cp0_wr_o,
    output logic                                     ok_o
);

    localparam int DataW = mips_exe_pkg::DataW;

    mips_exe_pkg::alu_op_e op;
    logic [DataW-1:0]      a;
    logic [DataW-1:0]      b;
    logic [DataW-1:0]      logic_res;
    logic [DataW-1:0]      shift_res;
    logic [DataW-1:0]      arith_res;
    logic [DataW-1:0]      move_res;
    logic [DataW-1:0]      cp0_fwd;
    logic [DataW:0]        sum_ext;
    logic [2*DataW-1:0]    mul_res;
    logic                  ovf;
    logic                  is_div;
    logic                  div_busy_q;

    assign op = req_i.op;
    assign a  = req_i.reg1;
    assign b  = req_i.reg2;

    always_comb begin
        case (op)
            mips_exe_pkg::OP_OR:  logic_res = a | b;
            mips_exe_pkg::OP_AND: logic_res = a & b;
            mips_exe_pkg::OP_XOR: logic_res = a ^ b;
            mips_exe_pkg::OP_NOR: logic_res = ~(a | b);
            mips_exe_pkg::OP_LUI: logic_res = b; // upper immediate already shifted
            default:              logic_res = '0;
        endcase
    end

    // shift amount always in reg1[4:0]
    always_comb begin
        case (op)
            mips_exe_pkg::OP_SLL: shift_res = b << a[4:0];
            mips_exe_pkg::OP_SRL: shift_res = b >> a[4:0];
            mips_exe_pkg::OP_SRA: shift_res = $unsigned($signed(b) >>> a[4:0]);
            default:              shift_res = '0;
        endcase
    end

    always_comb begin
        case (op)
            mips_exe_pkg::OP_ADD, mips_exe_pkg::OP_ADDU:
                sum_ext = {a[DataW-1], a} + {b[DataW-1], b};
            mips_exe_pkg::OP_SUB, mips_exe_pkg::OP_SUBU:
                sum_ext = {a[DataW-1], a} - {b[DataW-1], b};
            default:
                sum_ext = '0;
        endcase
    end

    // sign bits disagree on signed add/sub
    assign ovf = (op == mips_exe_pkg::OP_ADD || op == mips_exe_pkg::OP_SUB)
                 && (sum_ext[DataW] ^ sum_ext[DataW-1]);

    always_comb begin
        case (op)
            mips_exe_pkg::OP_ADD, mips_exe_pkg::OP_ADDU,
            mips_exe_pkg::OP_SUB, mips_exe_pkg::OP_SUBU: arith_res = sum_ext[DataW-1:0];
            mips_exe_pkg::OP_SLT:  arith_res = DataW'($signed(a) < $signed(b));
            mips_exe_pkg::OP_SLTU: arith_res = DataW'(a < b);
            mips_exe_pkg::OP_JAL:  arith_res = b; // link address
            default:               arith_res = '0;
        endcase
    end

    // sign-extended to full width, low 64 bits give the signed product
    always_comb begin
        case (op)
            mips_exe_pkg::OP_MULT:  mul_res = {{DataW{a[DataW-1]}}, a} * {{DataW{b[DataW-1]}}, b};
            mips_exe_pkg::OP_MULTU: mul_res = {{DataW{1'b0}}, a} * {{DataW{1'b0}}, b};
            default:                mul_res = '0;
        endcase
    end

    // newest pending cp0 write wins
    always_comb begin
        if (mem_cp0_i.we && mem_cp0_i.addr == req_i.rd) begin
            cp0_fwd = mem_cp0_i.data;
        end else if (wb_cp0_i.we && wb_cp0_i.addr == req_i.rd) begin
            cp0_fwd = wb_cp0_i.data;
        end else begin
            cp0_fwd = cp0_rdata_i;
        end
    end

    always_comb begin
        case (op)
            mips_exe_pkg::OP_MFHI: move_res = hi_i;
            mips_exe_pkg::OP_MFLO: move_res = lo_i;
            mips_exe_pkg::OP_MTHI,
            mips_exe_pkg::OP_MTLO: move_res = a;
            mips_exe_pkg::OP_MFC0: move_res = cp0_fwd;
            default:               move_res = '0;
        endcase
    end

    always_comb begin
        cp0_wr_o.we   = (op == mips_exe_pkg::OP_MTC0);
        cp0_wr_o.addr = req_i.rd;
        cp0_wr_o.data = a;
    end

    always_comb begin
        case (op)
            mips_exe_pkg::OP_TEQ:  res_o.exc_trap = (a == b);
            mips_exe_pkg::OP_TNE:  res_o.exc_trap = (a != b);
            mips_exe_pkg::OP_TGE:  res_o.exc_trap = ($signed(a) >= $signed(b));
            mips_exe_pkg::OP_TGEU: res_o.exc_trap = (a >= b);
            mips_exe_pkg::OP_TLT:  res_o.exc_trap = ($signed(a) < $signed(b));
            mips_exe_pkg::OP_TLTU: res_o.exc_trap = (a < b);
            default:               res_o.exc_trap = 1'b0;
        endcase
    end

    assign res_o.exc_ovf = ovf;

    assign is_div       = (op == mips_exe_pkg::OP_DIV || op == mips_exe_pkg::OP_DIVU);
    assign div_signed_o = (op == mips_exe_pkg::OP_DIV);
    assign div_start_o  = is_div && !div_ready_i && !div_busy_q;
    assign ok_o         = !(is_div && !div_ready_i);

    // divide in flight, blocks a second start
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_busy_q <= 1'b0;
        end else if (div_ready_i) begin
            div_busy_q <= 1'b0;
        end else if (div_start_o) begin
            div_busy_q <= 1'b1;
        end
    end

    always_comb begin
        case (req_i.sel)
            mips_exe_pkg::SEL_LOGIC: res_o.wdata = {logic_res, logic_res};
            mips_exe_pkg::SEL_SHIFT: res_o.wdata = {shift_res, shift_res};
            mips_exe_pkg::SEL_MOVE:  res_o.wdata = {move_res, move_res};
            mips_exe_pkg::SEL_ARITH: res_o.wdata = ovf ? '0 : {arith_res, arith_res};
            mips_exe_pkg::SEL_MUL:   res_o.wdata = mul_res;
            mips_exe_pkg::SEL_DIV:   res_o.wdata = div_ready_i ? {div_r_i, div_q_i} : '0;
            mips_exe_pkg::SEL_STORE: res_o.wdata = {b, b}; // store data
            default:                 res_o.wdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* exe_div.sv */
`timescale 1ns/100ps
`default_nettype none

module exe_div #(
    parameter int DivIter = 32
) (
    input  wire logic                           clk_i,
    input  wire logic                           arst_n_i,
    input  wire logic                           start_i,
    input  wire logic                           signed_i,
    input  wire logic [mips_exe_pkg::DataW-1:0] dividend_i,
    input  wire logic [mips_exe_pkg::DataW-1:0] divisor_i,
    output logic      [mips_exe_pkg::DataW-1:0] quot_o,
    output logic      [mips_exe_pkg::DataW-1:0] rem_o,
    output logic                                ready_o
);

    localparam int DataW = mips_exe_pkg::DataW;
    localparam int CntW  = $clog2(DivIter + 1);

    logic             busy_q;
    logic [CntW-1:0]  cnt_q;
    logic             load;
    logic             last;
    logic [DataW-1:0] a_mag;
    logic [DataW-1:0] b_mag;
    logic [DataW-1:0] rem_q;
    logic [DataW-1:0] quot_q;
    logic [DataW-1:0] dvsr_q;
    logic             neg_q_q;
    logic             neg_r_q;
    logic [DataW:0]   trial;

    assign load = start_i && !busy_q;
    assign last = busy_q && (cnt_q == CntW'(DivIter - 1));

    // magnitudes for the signed case
    assign a_mag = (signed_i && dividend_i[DataW-1]) ? -dividend_i : dividend_i;
    assign b_mag = (signed_i && divisor_i[DataW-1])  ? -divisor_i  : divisor_i;

    // shift in next dividend bit, try subtracting
    assign trial = {rem_q, quot_q[DataW-1]} - {1'b0, dvsr_q};

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q  <= 1'b0;
            cnt_q   <= '0;
            ready_o <= 1'b0;
        end else begin
            ready_o <= last; // single-cycle pulse
            if (load) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (last) begin
                busy_q <= 1'b0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            rem_q   <= '0;
            quot_q  <= a_mag;
            dvsr_q  <= b_mag;
            // zero divisor keeps quotient all ones
            neg_q_q <= signed_i && (dividend_i[DataW-1] ^ divisor_i[DataW-1]) && (|divisor_i);
            neg_r_q <= signed_i && dividend_i[DataW-1];
        end else if (busy_q) begin
            if (!trial[DataW]) begin
                rem_q  <= trial[DataW-1:0];
                quot_q <= {quot_q[DataW-2:0], 1'b1};
            end else begin
                rem_q  <= {rem_q[DataW-2:0], quot_q[DataW-1]};
                quot_q <= {quot_q[DataW-2:0], 1'b0};
            end
        end
    end

    // remainder follows the dividend sign
    assign quot_o = neg_q_q ? -quot_q : quot_q;
    assign rem_o  = neg_r_q ? -rem_q  : rem_q;

endmodule

`default_nettype wire

/* exe_top.sv */
`timescale 1ns/100ps
`default_nettype none

module exe_top #(
    parameter int DivIter = mips_exe_pkg::DivIter
) (
    input  wire logic                           clk_i,
    input  wire logic                           arst_n_i,
    input  wire mips_exe_pkg::exe_req_t         req_i,
    input  wire logic [mips_exe_pkg::DataW-1:0] cp0_rdata_i,
    input  wire mips_exe_pkg::cp0_wr_t          mem_cp0_i,
    input  wire mips_exe_pkg::cp0_wr_t          wb_cp0_i,
    output mips_exe_pkg::exe_res_t              res_o,
    output mips_exe_pkg::cp0_wr_t               cp0_wr_o,
    output logic                                ok_o
);

    logic                           div_start;
    logic                           div_signed;
    logic                           div_ready;
    logic [mips_exe_pkg::DataW-1:0] div_q;
    logic [mips_exe_pkg::DataW-1:0] div_r;
    logic [mips_exe_pkg::DataW-1:0] hi;
    logic [mips_exe_pkg::DataW-1:0] lo;

    exe_alu i_exe_alu (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_i        (req_i),
        .hi_i         (hi),
        .lo_i         (lo),
        .cp0_rdata_i  (cp0_rdata_i),
        .mem_cp0_i    (mem_cp0_i),
        .wb_cp0_i     (wb_cp0_i),
        .div_q_i      (div_q),
        .div_r_i      (div_r),
        .div_ready_i  (div_ready),
        .div_start_o  (div_start),
        .div_signed_o (div_signed),
        .res_o        (res_o),
        .cp0_wr_o     (cp0_wr_o),
        .ok_o         (ok_o)
    );

    // operands held upstream while ok_o is low
    exe_div #(
        .DivIter (DivIter)
    ) i_exe_div (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .start_i    (div_start),
        .signed_i   (div_signed),
        .dividend_i (req_i.reg1),
        .divisor_i  (req_i.reg2),
        .quot_o     (div_q),
        .rem_o      (div_r),
        .ready_o    (div_ready)
    );

    hilo_regs i_hilo_regs (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .op_i     (req_i.op),
        .reg1_i   (req_i.reg1),
        .wdata_i  (res_o.wdata),
        .ok_i     (ok_o),
        .hi_o     (hi),
        .lo_o     (lo)
    );

endmodule

`default_nettype wire

/* exe_top_props.sv */
`timescale 1ns/100ps
`default_nettype none

module exe_top_props (
    input wire logic                   clk_i,
    input wire logic                   arst_n_i,
    input wire mips_exe_pkg::exe_req_t req_i,
    input wire mips_exe_pkg::cp0_wr_t  cp0_wr_i,
    input wire logic                   ok_i
);

    // no stall while in reset
    assert property (@(posedge clk_i) !arst_n_i |-> ok_i)
        else $error("ok_o low during reset");

    assert property (@(posedge clk_i) disable iff (!arst_n_i) $fell(ok_i) |-> ##33 $rose(ok_i))
        else $error("divide stall did not end 33 cycles after ok_o fell");

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
                     cp0_wr_i.we |-> req_i.op == mips_exe_pkg::OP_MTC0)
        else $error("cp0 write enabled by an op other than MTC0");

endmodule

bind exe_top exe_top_props i_exe_top_props (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (req_i),
    .cp0_wr_i (cp0_wr_o),
    .ok_i     (ok_o)
);

`default_nettype wire

/* hilo_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module hilo_regs (
    input  wire logic                             clk_i,
    input  wire logic                             arst_n_i,
    input  wire mips_exe_pkg::alu_op_e            op_i,
    input  wire logic [mips_exe_pkg::DataW-1:0]   reg1_i,
    input  wire logic [2*mips_exe_pkg::DataW-1:0] wdata_i,
    input  wire logic                             ok_i,
    output logic      [mips_exe_pkg::DataW-1:0]   hi_o,
    output logic      [mips_exe_pkg::DataW-1:0]   lo_o
);

    localparam int DataW = mips_exe_pkg::DataW;

    // written on the completing edge only
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hi_o <= '0;
            lo_o <= '0;
        end else if (ok_i) begin
            case (op_i)
                mips_exe_pkg::OP_MULT, mips_exe_pkg::OP_MULTU,
                mips_exe_pkg::OP_DIV, mips_exe_pkg::OP_DIVU: begin
                    hi_o <= wdata_i[2*DataW-1:DataW]; // product high or remainder
                    lo_o <= wdata_i[DataW-1:0];
                end
                mips_exe_pkg::OP_MTHI: hi_o <= reg1_i;
                mips_exe_pkg::OP_MTLO: lo_o <= reg1_i;
                default: begin
                    hi_o <= hi_o;
                    lo_o <= lo_o;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* mips_exe_pkg.sv */
`default_nettype none

package mips_exe_pkg;

    localparam int DataW    = 32;
    localparam int Cp0AddrW = 5;
    localparam int DivIter  = 32; // one iteration per quotient bit

    // immediate forms share the register-form code
    typedef enum logic [5:0] {
        OP_NOP   = 6'h00,
        OP_OR    = 6'h01,
        OP_AND   = 6'h02,
        OP_XOR   = 6'h03,
        OP_NOR   = 6'h04,
        OP_LUI   = 6'h05,
        OP_SLL   = 6'h06,
        OP_SRL   = 6'h07,
        OP_SRA   = 6'h08,
        OP_ADD   = 6'h09,
        OP_ADDU  = 6'h0a,
        OP_SUB   = 6'h0b,
        OP_SUBU  = 6'h0c,
        OP_SLT   = 6'h0d,
        OP_SLTU  = 6'h0e,
        OP_MULT  = 6'h0f,
        OP_MULTU = 6'h10,
        OP_DIV   = 6'h11,
        OP_DIVU  = 6'h12,
        OP_MFHI  = 6'h13,
        OP_MFLO  = 6'h14,
        OP_MTHI  = 6'h15,
        OP_MTLO  = 6'h16,
        OP_MFC0  = 6'h17,
        OP_MTC0  = 6'h18,
        OP_TEQ   = 6'h19,
        OP_TNE   = 6'h1a,
        OP_TGE   = 6'h1b,
        OP_TGEU  = 6'h1c,
        OP_TLT   = 6'h1d,
        OP_TLTU  = 6'h1e,
        OP_JAL   = 6'h1f,
        OP_STORE = 6'h20
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_LOGIC = 3'd0,
        SEL_SHIFT = 3'd1,
        SEL_MOVE  = 3'd2,
        SEL_ARITH = 3'd3,
        SEL_MUL   = 3'd4,
        SEL_DIV   = 3'd5,
        SEL_STORE = 3'd6,
        SEL_NONE  = 3'd7
    } alu_sel_e;

    typedef struct packed {
        alu_op_e             op;
        alu_sel_e            sel;
        logic [DataW-1:0]    reg1;
        logic [DataW-1:0]    reg2;   // immediate already placed here by decode
        logic [Cp0AddrW-1:0] rd;     // cp0 register number
    } exe_req_t;

    typedef struct packed {
        logic [2*DataW-1:0] wdata;  // hi half / lo half
        logic               exc_ovf;
        logic               exc_trap;
    } exe_res_t;

    typedef struct packed {
        logic                we;
        logic [Cp0AddrW-1:0] addr;
        logic [DataW-1:0]    data;
    } cp0_wr_t;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_exe_top \
    -Mdir obj_dir -o sim_exe -f src.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_exe
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

/* src.f */
mips_exe_pkg.sv
exe_div.sv
hilo_regs.sv
exe_alu.sv
exe_top.sv
exe_top_props.sv
tb_exe_top.sv

/* tb_exe_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_exe_top;

    localparam int DataW     = mips_exe_pkg::DataW;
    localparam int ClkPeriod = 10;
    localparam int NumAlu    = 240;
    localparam int NumMul    = 20;
    localparam int NumDiv    = 30;
    localparam int NumCp0    = 40;
    localparam int NumTests  = 2 + NumAlu + 7 * NumMul + 3 * NumDiv + 2 * NumCp0;

    logic                   clk;
    logic                   arst_n;
    mips_exe_pkg::exe_req_t req;
    logic [DataW-1:0]       cp0_rdata;
    mips_exe_pkg::cp0_wr_t  mem_cp0;
    mips_exe_pkg::cp0_wr_t  wb_cp0;
    mips_exe_pkg::exe_res_t res;
    mips_exe_pkg::cp0_wr_t  cp0_wr;
    logic                   ok;
    logic [31:0]            lfsr_q;
    logic [DataW-1:0]       hi_m;
    logic [DataW-1:0]       lo_m;
    logic [DataW-1:0]       cp0_m [32]; // shadow of the outside cp0 file

    mips_exe_pkg::alu_op_e alu_ops [22] = '{
        mips_exe_pkg::OP_OR, mips_exe_pkg::OP_AND, mips_exe_pkg::OP_XOR, mips_exe_pkg::OP_NOR,
        mips_exe_pkg::OP_LUI, mips_exe_pkg::OP_SLL, mips_exe_pkg::OP_SRL, mips_exe_pkg::OP_SRA,
        mips_exe_pkg::OP_ADD, mips_exe_pkg::OP_ADDU, mips_exe_pkg::OP_SUB, mips_exe_pkg::OP_SUBU,
        mips_exe_pkg::OP_SLT, mips_exe_pkg::OP_SLTU, mips_exe_pkg::OP_JAL, mips_exe_pkg::OP_STORE,
        mips_exe_pkg::OP_TEQ, mips_exe_pkg::OP_TNE, mips_exe_pkg::OP_TGE, mips_exe_pkg::OP_TGEU,
        mips_exe_pkg::OP_TLT, mips_exe_pkg::OP_TLTU
    };

    exe_top i_exe_top (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .req_i       (req),
        .cp0_rdata_i (cp0_rdata),
        .mem_cp0_i   (mem_cp0),
        .wb_cp0_i    (wb_cp0),
        .res_o       (res),
        .cp0_wr_o    (cp0_wr),
        .ok_o        (ok)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #((8 + NumTests * 40) * ClkPeriod);
        $display("watchdog expired, tests did not finish within %0d cycles", 8 + NumTests * 40);
        abort_run();
    end

    // galois lfsr, one step per bit
    function automatic logic [DataW-1:0] rand_bits(int n);
        logic [DataW-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'ha300_0000) : (lfsr_q >> 1);
            v = {v[DataW-2:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [DataW-1:0] rand_operand();
        case (3'(rand_bits(3)))
            3'd0:    return '0;
            3'd1:    return 32'h0000_0001;
            3'd2:    return 32'h7fff_ffff;
            3'd3:    return 32'h8000_0000;
            3'd4:    return '1;
            default: return rand_bits(DataW);
        endcase
    endfunction

    function automatic mips_exe_pkg::alu_sel_e sel_of(mips_exe_pkg::alu_op_e op);
        case (op)
            mips_exe_pkg::OP_OR, mips_exe_pkg::OP_AND, mips_exe_pkg::OP_XOR, mips_exe_pkg::OP_NOR,
            mips_exe_pkg::OP_LUI: return mips_exe_pkg::SEL_LOGIC;
            mips_exe_pkg::OP_SLL, mips_exe_pkg::OP_SRL,
            mips_exe_pkg::OP_SRA: return mips_exe_pkg::SEL_SHIFT;
            mips_exe_pkg::OP_MFHI, mips_exe_pkg::OP_MFLO, mips_exe_pkg::OP_MTHI,
            mips_exe_pkg::OP_MTLO, mips_exe_pkg::OP_MFC0: return mips_exe_pkg::SEL_MOVE;
            mips_exe_pkg::OP_ADD, mips_exe_pkg::OP_ADDU, mips_exe_pkg::OP_SUB, mips_exe_pkg::OP_SUBU,
            mips_exe_pkg::OP_SLT, mips_exe_pkg::OP_SLTU,
            mips_exe_pkg::OP_JAL: return mips_exe_pkg::SEL_ARITH;
            mips_exe_pkg::OP_MULT, mips_exe_pkg::OP_MULTU: return mips_exe_pkg::SEL_MUL;
            mips_exe_pkg::OP_DIV, mips_exe_pkg::OP_DIVU: return mips_exe_pkg::SEL_DIV;
            mips_exe_pkg::OP_STORE: return mips_exe_pkg::SEL_STORE;
            default: return mips_exe_pkg::SEL_NONE;
        endcase
    endfunction

    function automatic mips_exe_pkg::exe_req_t make_req(mips_exe_pkg::alu_op_e op,
            logic [DataW-1:0] a, logic [DataW-1:0] b, logic [4:0] rd);
        return '{op: op, sel: sel_of(op), reg1: a, reg2: b, rd: rd};
    endfunction

    function automatic logic signed_lt(logic [DataW-1:0] a, logic [DataW-1:0] b);
        return (a[DataW-1] != b[DataW-1]) ? a[DataW-1] : (a < b);
    endfunction

    function automatic logic [DataW-1:0] mag(logic [DataW-1:0] v, logic sgn);
        return (sgn && v[DataW-1]) ? -v : v;
    endfunction

    // truncating divide, remainder keeps the dividend sign
    function automatic logic [2*DataW-1:0] div_model(logic [DataW-1:0] a, logic [DataW-1:0] b,
            logic sgn);
        logic [DataW-1:0] q;
        logic [DataW-1:0] r;
        if (b == '0) return {a, {DataW{1'b1}}};
        q = mag(a, sgn) / mag(b, sgn);
        r = mag(a, sgn) % mag(b, sgn);
        if (sgn && (a[DataW-1] ^ b[DataW-1])) q = -q;
        if (sgn && a[DataW-1]) r = -r;
        return {r, q};
    endfunction

    function automatic mips_exe_pkg::exe_res_t model_result(mips_exe_pkg::exe_req_t r,
            mips_exe_pkg::cp0_wr_t mem, mips_exe_pkg::cp0_wr_t wb, logic [DataW-1:0] cp0_rd);
        mips_exe_pkg::exe_res_t e;
        logic [DataW-1:0]       a;
        logic [DataW-1:0]       b;
        logic [DataW-1:0]       w;
        logic [2*DataW-1:0]     p;
        logic                   sgn;
        a = r.reg1;
        b = r.reg2;
        w = '0;
        e = '0;
        case (r.op)
            mips_exe_pkg::OP_OR:  w = a | b;
            mips_exe_pkg::OP_AND: w = a & b;
            mips_exe_pkg::OP_XOR: w = a ^ b;
            mips_exe_pkg::OP_NOR: w = ~(a | b);
            mips_exe_pkg::OP_LUI, mips_exe_pkg::OP_JAL, mips_exe_pkg::OP_STORE: w = b;
            mips_exe_pkg::OP_SLL: w = b << a[4:0];
            mips_exe_pkg::OP_SRL: w = b >> a[4:0];
            mips_exe_pkg::OP_SRA: w = (b >> a[4:0]) | (b[DataW-1] ? ~({DataW{1'b1}} >> a[4:0]) : '0);
            mips_exe_pkg::OP_ADD, mips_exe_pkg::OP_ADDU: begin
                w = a + b;
                e.exc_ovf = (r.op == mips_exe_pkg::OP_ADD) && (a[31] == b[31]) && (w[31] != a[31]);
            end
            mips_exe_pkg::OP_SUB, mips_exe_pkg::OP_SUBU: begin
                w = a - b;
                e.exc_ovf = (r.op == mips_exe_pkg::OP_SUB) && (a[31] != b[31]) && (w[31] != a[31]);
            end
            mips_exe_pkg::OP_SLT:  w = DataW'(signed_lt(a, b));
            mips_exe_pkg::OP_SLTU: w = DataW'(a < b);
            mips_exe_pkg::OP_MFHI: w = hi_m;
            mips_exe_pkg::OP_MFLO: w = lo_m;
            mips_exe_pkg::OP_MTHI, mips_exe_pkg::OP_MTLO: w = a;
            mips_exe_pkg::OP_MFC0: w = (mem.we && mem.addr == r.rd) ? mem.data
                                     : (wb.we && wb.addr == r.rd) ? wb.data : cp0_rd;
            mips_exe_pkg::OP_TEQ:  e.exc_trap = (a == b);
            mips_exe_pkg::OP_TNE:  e.exc_trap = (a != b);
            mips_exe_pkg::OP_TGE:  e.exc_trap = !signed_lt(a, b);
            mips_exe_pkg::OP_TGEU: e.exc_trap = (a >= b);
            mips_exe_pkg::OP_TLT:  e.exc_trap = signed_lt(a, b);
            mips_exe_pkg::OP_TLTU: e.exc_trap = (a < b);
            default: ;
        endcase
        e.wdata = e.exc_ovf ? '0 : {w, w};
        sgn = (r.op == mips_exe_pkg::OP_MULT) || (r.op == mips_exe_pkg::OP_DIV);
        if (r.op == mips_exe_pkg::OP_MULT || r.op == mips_exe_pkg::OP_MULTU) begin
            p = {{DataW{1'b0}}, mag(a, sgn)} * {{DataW{1'b0}}, mag(b, sgn)};
            e.wdata = (sgn && (a[DataW-1] ^ b[DataW-1])) ? -p : p;
        end
        if (r.op == mips_exe_pkg::OP_DIV || r.op == mips_exe_pkg::OP_DIVU) begin
            e.wdata = div_model(a, b, sgn);
        end
        return e;
    endfunction

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_res(mips_exe_pkg::exe_res_t got, mips_exe_pkg::exe_res_t exp,
            string what);
        if (got !== exp) begin
            $display("ERR %0t %s: wdata %h ovf %b trap %b, expected wdata %h ovf %b trap %b",
                     $time, what, got.wdata, got.exc_ovf, got.exc_trap,
                     exp.wdata, exp.exc_ovf, exp.exc_trap);
            abort_run();
        end
    endtask

    task automatic check_cp0(mips_exe_pkg::cp0_wr_t got, mips_exe_pkg::cp0_wr_t exp, string what);
        if (got.we !== exp.we || (exp.we && (got.addr !== exp.addr || got.data !== exp.data))) begin
            $display("ERR %0t %s: cp0 write we %b addr %0d data %h, expected we %b addr %0d data %h",
                     $time, what, got.we, got.addr, got.data, exp.we, exp.addr, exp.data);
            abort_run();
        end
    endtask

    task automatic check_ok(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("ERR %0t %s: ok_o %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // one instruction from drive to its completing edge
    task automatic run_op(mips_exe_pkg::exe_req_t r, mips_exe_pkg::cp0_wr_t mem,
            mips_exe_pkg::cp0_wr_t wb);
        mips_exe_pkg::exe_res_t exp_res;
        mips_exe_pkg::cp0_wr_t  exp_cp0;
        int                     stall;
        @(posedge clk);
        #1;
        req       = r;
        mem_cp0   = mem;
        wb_cp0    = wb;
        cp0_rdata = cp0_m[r.rd];
        exp_res   = model_result(r, mem, wb, cp0_m[r.rd]);
        exp_cp0   = '{we: (r.op == mips_exe_pkg::OP_MTC0), addr: r.rd, data: r.reg1};
        stall = (r.op == mips_exe_pkg::OP_DIV || r.op == mips_exe_pkg::OP_DIVU) ?
                mips_exe_pkg::DivIter + 1 : 0;
        @(negedge clk);
        repeat (stall) begin
            check_ok(ok, 1'b0, "divide stall");
            @(negedge clk);
        end
        check_ok(ok, 1'b1, r.op.name());
        check_res(res, exp_res, r.op.name());
        check_cp0(cp0_wr, exp_cp0, r.op.name());
        if (sel_of(r.op) == mips_exe_pkg::SEL_MUL || sel_of(r.op) == mips_exe_pkg::SEL_DIV) begin
            hi_m = exp_res.wdata[2*DataW-1:DataW];
            lo_m = exp_res.wdata[DataW-1:0];
        end
        if (r.op == mips_exe_pkg::OP_MTHI) hi_m = r.reg1;
        if (r.op == mips_exe_pkg::OP_MTLO) lo_m = r.reg1;
        if (r.op == mips_exe_pkg::OP_MTC0) cp0_m[r.rd] = r.reg1;
    endtask

    initial begin
        mips_exe_pkg::cp0_wr_t m;
        mips_exe_pkg::cp0_wr_t w;
        mips_exe_pkg::alu_op_e op;
        logic [DataW-1:0]      a;
        logic [DataW-1:0]      b;
        logic [4:0]            rd;
        lfsr_q    = 32'd40040;
        hi_m      = '0;
        lo_m      = '0;
        arst_n    = 1'b0;
        req       = make_req(mips_exe_pkg::OP_NOP, '0, '0, '0);
        cp0_rdata = '0;
        mem_cp0   = '0;
        wb_cp0    = '0;
        for (int i = 0; i < 32; i++) begin
            cp0_m[5'(i)] = 32'h5a00_0000 ^ (DataW'(i) * 32'h0101_0101);
        end
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        run_op(make_req(mips_exe_pkg::OP_MFHI, '0, '0, '0), '0, '0); // cleared by reset
        run_op(make_req(mips_exe_pkg::OP_MFLO, '0, '0, '0), '0, '0);
        repeat (NumAlu) begin
            a  = rand_operand();
            b  = (rand_bits(2) == '0) ? a : rand_operand();
            rd = 5'(int'(rand_bits(5)) % 22);
            run_op(make_req(alu_ops[rd], a, b, '0), '0, '0);
        end
        repeat (NumMul) begin
            a  = rand_operand();
            b  = rand_operand();
            op = mips_exe_pkg::OP_MULT;
            if (rand_bits(1) != '0) op = mips_exe_pkg::OP_MULTU;
            run_op(make_req(op, a, b, '0), '0, '0);
            run_op(make_req(mips_exe_pkg::OP_MFHI, '0, '0, '0), '0, '0);
            run_op(make_req(mips_exe_pkg::OP_MFLO, '0, '0, '0), '0, '0);
            run_op(make_req(mips_exe_pkg::OP_MTHI, rand_bits(DataW), '0, '0), '0, '0);
            run_op(make_req(mips_exe_pkg::OP_MTLO, rand_bits(DataW), '0, '0), '0, '0);
            run_op(make_req(mips_exe_pkg::OP_MFHI, '0, '0, '0), '0, '0);
            run_op(make_req(mips_exe_pkg::OP_MFLO, '0, '0, '0), '0, '0);
        end
        repeat (NumDiv) begin
            a  = rand_operand();
            b  = (rand_bits(2) == '0) ? '0 : rand_operand(); // zero divisor one time in four
            op = mips_exe_pkg::OP_DIV;
            if (rand_bits(1) != '0) op = mips_exe_pkg::OP_DIVU;
            run_op(make_req(op, a, b, '0), '0, '0);
            run_op(make_req(mips_exe_pkg::OP_MFHI, '0, '0, '0), '0, '0);
            run_op(make_req(mips_exe_pkg::OP_MFLO, '0, '0, '0), '0, '0);
        end
        repeat (NumCp0) begin
            rd = 5'(rand_bits(5));
            run_op(make_req(mips_exe_pkg::OP_MTC0, rand_bits(DataW), '0, rd), '0, '0);
            m.we   = 1'(rand_bits(1));
            m.addr = (rand_bits(1) != '0) ? rd : 5'(rand_bits(5));
            m.data = rand_bits(DataW);
            w.we   = 1'(rand_bits(1));
            w.addr = (rand_bits(1) != '0) ? rd : 5'(rand_bits(5));
            w.data = rand_bits(DataW);
            run_op(make_req(mips_exe_pkg::OP_MFC0, '0, '0, rd), m, w);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire
